// File: verilog/smem_pkg.sv
package smem_pkg;

	// ----------------------------------------
	// batch and queue sizes
	// ----------------------------------------
	localparam int NUM_READS  = 16;
	localparam int READ_NUM_W = 4;
	localparam int NUM_SLOTS  = 8;
	localparam int SLOT_W     = 3;
	localparam int SLOT_DEPTH = NUM_READS * NUM_SLOTS;
	localparam int MEM_SIZE_W = 4;
	localparam int BATCH_W    = 5;
	localparam int RET_W      = 32;

	// lane layout of a queue entry: {info, x2, x1, x0}
	localparam int LANE_W      = 64;
	localparam int X_W         = 33;
	localparam int INFO_W      = 7;
	// info lane carries two 7-bit pieces, at bit 0 and bit 32 of the lane
	localparam int INFO_HI_OFS = 32;
	localparam int X0_LSB      = 0;
	localparam int X1_LSB      = LANE_W;
	localparam int X2_LSB      = 2 * LANE_W;
	localparam int INFO_LSB    = 3 * LANE_W;

	// header beat fields
	localparam int HDR_IDX_W    = 10;
	localparam int HDR_SIZE_LSB = 64;
	localparam int HDR_RET_LSB  = 128;

	typedef logic [4*LANE_W-1:0]          entry_t;
	typedef logic [3*X_W+2*INFO_W-1:0]    packed_slot_t;
	typedef logic [8*LANE_W-1:0]          out_word_t;
	typedef logic [READ_NUM_W-1:0]        read_num_t;
	typedef logic [SLOT_W-1:0]            slot_addr_t;
	typedef logic [MEM_SIZE_W-1:0]        mem_size_t;
	typedef logic [RET_W-1:0]             ret_t;

	// keep only the significant low bits of every lane
	function automatic packed_slot_t pack_slot(input entry_t e);
		return {e[INFO_LSB+INFO_HI_OFS +: INFO_W],
			e[INFO_LSB +: INFO_W],
			e[X2_LSB +: X_W],
			e[X1_LSB +: X_W],
			e[X0_LSB +: X_W]};
	endfunction

	// back to lane positions, everything else zero
	function automatic entry_t unpack_slot(input packed_slot_t p);
		entry_t e;
		e = '0;
		e[X0_LSB +: X_W] = p[0 +: X_W];
		e[X1_LSB +: X_W] = p[X_W +: X_W];
		e[X2_LSB +: X_W] = p[2*X_W +: X_W];
		e[INFO_LSB +: INFO_W] = p[3*X_W +: INFO_W];
		e[INFO_LSB+INFO_HI_OFS +: INFO_W] = p[3*X_W+INFO_W +: INFO_W];
		return e;
	endfunction

endpackage

// File: verilog/slot_queue_ram.sv
`timescale 1ns/1ps

module slot_queue_ram
	import smem_pkg::*;
(
	input  logic       clk,

	// port 1
	input  read_num_t  read_num_1,
	input  logic       we_1,
	input  entry_t     data_1,
	input  slot_addr_t addr_1,
	output entry_t     q_1,

	// port 2
	input  read_num_t  read_num_2,
	input  logic       we_2,
	input  entry_t     data_2,
	input  slot_addr_t addr_2,
	output entry_t     q_2
);

	// one row per read, NUM_SLOTS slots per row, pruned form only
	packed_slot_t slots [SLOT_DEPTH];

	logic [READ_NUM_W+SLOT_W-1:0] idx_1;
	logic [READ_NUM_W+SLOT_W-1:0] idx_2;

	assign idx_1 = {read_num_1, addr_1};
	assign idx_2 = {read_num_2, addr_2};

	// ----------------------------------------
	// ports 1 and 2
	// ----------------------------------------
	// port 2 wins when both write the same slot
	always_ff @(posedge clk) begin
		if (we_1) begin
			slots[idx_1] <= pack_slot(data_1);
			// write-through returns the full word, not the pruned one
			q_1 <= data_1;
		end else begin
			q_1 <= unpack_slot(slots[idx_1]);
		end
		if (we_2) begin
			slots[idx_2] <= pack_slot(data_2);
			q_2 <= data_2;
		end else begin
			q_2 <= unpack_slot(slots[idx_2]);
		end
	end

endmodule

// File: verilog/read_table.sv
`timescale 1ns/1ps

module read_table
	import smem_pkg::*;
#(
	parameter type entry_t = ret_t
)(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      wr,
	input  read_num_t wr_idx,
	input  entry_t    wr_val,
	input  read_num_t rd_idx,
	output entry_t    rd_val
);

	// one value per read of the batch
	entry_t tbl [NUM_READS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			// unwritten reads come back as zero
			tbl <= '{default: '0};
		end else if (wr) begin
			tbl[wr_idx] <= wr_val;
		end
	end

	// combinational lookup for the drain
	assign rd_val = tbl[rd_idx];

endmodule

// File: verilog/beat_formatter.sv
`timescale 1ns/1ps

module beat_formatter
	import smem_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      load,
	input  logic      hdr_sel,
	input  read_num_t read_idx,
	input  mem_size_t size,
	input  ret_t      ret,
	input  entry_t    slot_lo,
	input  entry_t    slot_hi,
	input  logic      hi_valid,
	output out_word_t beat,
	output logic      beat_valid
);

	out_word_t hdr_word;
	out_word_t pair_word;

	// ----------------------------------------
	// header beat: index, mem size, ret code
	// ----------------------------------------
	always_comb begin
		hdr_word = '0;
		hdr_word[HDR_IDX_W-1:0] = HDR_IDX_W'(read_idx);
		hdr_word[HDR_SIZE_LSB +: MEM_SIZE_W] = size;
		hdr_word[HDR_RET_LSB +: RET_W] = ret;
	end

	// ----------------------------------------
	// slot pair beat
	// ----------------------------------------
	// odd tail slot goes out alone, high half zero
	assign pair_word = {hi_valid ? slot_hi : entry_t'('0), slot_lo};

	// beat payload holds its last value between loads
	always_ff @(posedge clk) begin
		if (load) begin
			if (hdr_sel) begin
				beat <= hdr_word;
			end else begin
				beat <= pair_word;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= load;
		end
	end

endmodule

// File: verilog/smem_output_ctrl.sv
`timescale 1ns/1ps

module smem_output_ctrl
	import smem_pkg::*;
(
	input  logic               clk,
	input  logic               reset_n,
	input  logic [BATCH_W-1:0] batch_size,
	input  logic               mem_size_valid,
	input  logic               output_permit,
	input  logic               stall,

	// upstream mem queue ports
	input  read_num_t          mem_read_num_1,
	input  logic               mem_we_1,
	input  slot_addr_t         mem_addr_1,
	input  read_num_t          mem_read_num_2,
	input  logic               mem_we_2,
	input  slot_addr_t         mem_addr_2,

	// to mem_q
	output read_num_t          mq_read_num_1,
	output logic               mq_we_1,
	output slot_addr_t         mq_addr_1,
	output read_num_t          mq_read_num_2,
	output logic               mq_we_2,
	output slot_addr_t         mq_addr_2,

	// tables and formatter
	output read_num_t          tbl_idx,
	input  mem_size_t          cur_size,
	output logic               fmt_load,
	output logic               fmt_hdr_sel,
	output logic               fmt_hi_valid,

	output logic               output_request,
	output logic               output_finish
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_SLOTS,
		S_GAP,
		S_DONE
	} state_t;

	state_t             state;
	logic [BATCH_W-1:0] done_cnt;
	logic               batch_done;
	read_num_t          rd_ptr;
	// first slot of the pair currently on mem_q
	slot_addr_t         slot_ptr;
	slot_addr_t         rd_addr;
	mem_size_t          next_pos;
	logic               advance;
	logic               draining;
	logic               last_read;
	logic               pair_end;

	// ----------------------------------------
	// batch completion and request
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_cnt <= '0;
			batch_done <= 1'b0;
			output_request <= 1'b0;
		end else begin
			if (mem_size_valid && !batch_done) begin
				done_cnt <= done_cnt + 1'b1;
			end
			if (done_cnt == batch_size && batch_size != '0) begin
				batch_done <= 1'b1;
			end
			// request lags batch_done by one edge and stays up
			if (batch_done) begin
				output_request <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// drain sequencing
	// ----------------------------------------
	// stall and permit are sampled at the edge, nothing moves when either blocks
	assign advance   = output_permit && !stall;
	assign draining  = (state == S_HEADER) || (state == S_SLOTS) || (state == S_GAP);
	assign last_read = ({1'b0, rd_ptr} == batch_size - 1'b1);
	assign next_pos  = mem_size_t'(slot_ptr) + mem_size_t'(2);
	assign pair_end  = (next_pos >= cur_size);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			rd_ptr <= '0;
			slot_ptr <= '0;
			output_finish <= 1'b0;
		end else if (advance) begin
			case (state)
				S_IDLE: begin
					if (output_request) begin
						state <= S_HEADER;
					end
				end
				S_HEADER: begin
					state <= (cur_size == '0) ? S_GAP : S_SLOTS;
				end
				S_SLOTS: begin
					if (pair_end) begin
						state <= S_GAP;
					end else begin
						slot_ptr <= slot_ptr + 3'd2;
					end
				end
				S_GAP: begin
					slot_ptr <= '0;
					if (last_read) begin
						state <= S_DONE;
						output_finish <= 1'b1;
					end else begin
						rd_ptr <= rd_ptr + 1'b1;
						state <= S_HEADER;
					end
				end
				default: begin
					state <= S_DONE;
				end
			endcase
		end
	end

	// pair read runs one cycle ahead of the load
	// on a blocked cycle re-read the current pair so q stays put
	assign rd_addr = (state == S_SLOTS && advance) ? slot_ptr + 3'd2 : slot_ptr;

	// ----------------------------------------
	// mem port takeover
	// ----------------------------------------
	assign mq_read_num_1 = draining ? rd_ptr : mem_read_num_1;
	assign mq_we_1       = draining ? 1'b0 : mem_we_1;
	assign mq_addr_1     = draining ? rd_addr : mem_addr_1;
	assign mq_read_num_2 = draining ? rd_ptr : mem_read_num_2;
	assign mq_we_2       = draining ? 1'b0 : mem_we_2;
	assign mq_addr_2     = draining ? rd_addr + 1'b1 : mem_addr_2;

	assign tbl_idx      = rd_ptr;
	assign fmt_load     = advance && (state == S_HEADER || state == S_SLOTS);
	assign fmt_hdr_sel  = (state == S_HEADER);
	assign fmt_hi_valid = (mem_size_t'(slot_ptr) + 1'b1 < cur_size);

endmodule

// File: verilog/smem_result_buffer.sv
`timescale 1ns/1ps

module smem_result_buffer
	import smem_pkg::*;
(
	input  logic               clk,
	input  logic               reset_n,
	input  logic               stall,
	input  logic [BATCH_W-1:0] batch_size,

	// curr queue
	input  read_num_t          curr_read_num_1,
	input  logic               curr_we_1,
	input  entry_t             curr_data_1,
	input  slot_addr_t         curr_addr_1,
	output entry_t             curr_q_1,
	input  read_num_t          curr_read_num_2,
	input  logic               curr_we_2,
	input  entry_t             curr_data_2,
	input  slot_addr_t         curr_addr_2,
	output entry_t             curr_q_2,

	// mem queue
	input  read_num_t          mem_read_num_1,
	input  logic               mem_we_1,
	input  entry_t             mem_data_1,
	input  slot_addr_t         mem_addr_1,
	output entry_t             mem_q_1,
	input  read_num_t          mem_read_num_2,
	input  logic               mem_we_2,
	input  entry_t             mem_data_2,
	input  slot_addr_t         mem_addr_2,
	output entry_t             mem_q_2,

	// per-read results
	input  logic               mem_size_valid,
	input  mem_size_t          mem_size,
	input  read_num_t          mem_size_read_num,
	input  logic               ret_valid,
	input  ret_t               ret,
	input  read_num_t          ret_read_num,

	// output stream
	output logic               output_request,
	input  logic               output_permit,
	output out_word_t          output_data,
	output logic               output_valid,
	output logic               output_finish
);

	read_num_t  mq_read_num_1;
	logic       mq_we_1;
	slot_addr_t mq_addr_1;
	read_num_t  mq_read_num_2;
	logic       mq_we_2;
	slot_addr_t mq_addr_2;
	read_num_t  tbl_idx;
	mem_size_t  cur_size;
	ret_t       cur_ret;
	logic       fmt_load;
	logic       fmt_hdr_sel;
	logic       fmt_hi_valid;

	smem_output_ctrl ctrl (
		.clk            (clk),
		.reset_n        (reset_n),
		.batch_size     (batch_size),
		.mem_size_valid (mem_size_valid),
		.output_permit  (output_permit),
		.stall          (stall),
		.mem_read_num_1 (mem_read_num_1),
		.mem_we_1       (mem_we_1),
		.mem_addr_1     (mem_addr_1),
		.mem_read_num_2 (mem_read_num_2),
		.mem_we_2       (mem_we_2),
		.mem_addr_2     (mem_addr_2),
		.mq_read_num_1  (mq_read_num_1),
		.mq_we_1        (mq_we_1),
		.mq_addr_1      (mq_addr_1),
		.mq_read_num_2  (mq_read_num_2),
		.mq_we_2        (mq_we_2),
		.mq_addr_2      (mq_addr_2),
		.tbl_idx        (tbl_idx),
		.cur_size       (cur_size),
		.fmt_load       (fmt_load),
		.fmt_hdr_sel    (fmt_hdr_sel),
		.fmt_hi_valid   (fmt_hi_valid),
		.output_request (output_request),
		.output_finish  (output_finish)
	);

	// ----------------------------------------
	// slot queues
	// ----------------------------------------
	slot_queue_ram curr_q (
		.clk        (clk),
		.read_num_1 (curr_read_num_1),
		.we_1       (curr_we_1),
		.data_1     (curr_data_1),
		.addr_1     (curr_addr_1),
		.q_1        (curr_q_1),
		.read_num_2 (curr_read_num_2),
		.we_2       (curr_we_2),
		.data_2     (curr_data_2),
		.addr_2     (curr_addr_2),
		.q_2        (curr_q_2)
	);

	// write data goes straight in, the controller holds we low while draining
	slot_queue_ram mem_q (
		.clk        (clk),
		.read_num_1 (mq_read_num_1),
		.we_1       (mq_we_1),
		.data_1     (mem_data_1),
		.addr_1     (mq_addr_1),
		.q_1        (mem_q_1),
		.read_num_2 (mq_read_num_2),
		.we_2       (mq_we_2),
		.data_2     (mem_data_2),
		.addr_2     (mq_addr_2),
		.q_2        (mem_q_2)
	);

	// ----------------------------------------
	// per-read tables
	// ----------------------------------------
	read_table #(
		.entry_t (mem_size_t)
	) size_table (
		.clk     (clk),
		.reset_n (reset_n),
		.wr      (mem_size_valid),
		.wr_idx  (mem_size_read_num),
		.wr_val  (mem_size),
		.rd_idx  (tbl_idx),
		.rd_val  (cur_size)
	);

	read_table #(
		.entry_t (ret_t)
	) ret_table (
		.clk     (clk),
		.reset_n (reset_n),
		.wr      (ret_valid),
		.wr_idx  (ret_read_num),
		.wr_val  (ret),
		.rd_idx  (tbl_idx),
		.rd_val  (cur_ret)
	);

	beat_formatter formatter (
		.clk        (clk),
		.reset_n    (reset_n),
		.load       (fmt_load),
		.hdr_sel    (fmt_hdr_sel),
		.read_idx   (tbl_idx),
		.size       (cur_size),
		.ret        (cur_ret),
		.slot_lo    (mem_q_1),
		.slot_hi    (mem_q_2),
		.hi_valid   (fmt_hi_valid),
		.beat       (output_data),
		.beat_valid (output_valid)
	);

endmodule

// File: bench/smem_result_buffer_asserts.sv
`timescale 1ns/1ps

module smem_result_buffer_asserts (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input logic output_permit,
	input logic output_valid,
	input logic output_request,
	input logic output_finish
);

	int fail_count = 0;

	// ----------------------------------------
	// blocked edges load nothing
	// ----------------------------------------
	// a beat is loaded at an edge, so a blocked edge leaves the next cycle empty
	stall_blocks_beat: assert property (@(posedge clk) disable iff (!reset_n)
		stall |=> !output_valid)
		else begin
			$error("output_valid high after an edge with stall high");
			fail_count++;
		end

	permit_gates_beat: assert property (@(posedge clk) disable iff (!reset_n)
		!output_permit |=> !output_valid)
		else begin
			$error("output_valid high after an edge without output_permit");
			fail_count++;
		end

	// ----------------------------------------
	// sticky levels
	// ----------------------------------------
	request_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		output_request |=> output_request)
		else begin
			$error("output_request fell without a reset");
			fail_count++;
		end

	finish_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		output_finish |=> output_finish)
		else begin
			$error("output_finish fell without a reset");
			fail_count++;
		end

endmodule

bind smem_result_buffer smem_result_buffer_asserts i_asserts (
	.clk            (clk),
	.reset_n        (reset_n),
	.stall          (stall),
	.output_permit  (output_permit),
	.output_valid   (output_valid),
	.output_request (output_request),
	.output_finish  (output_finish)
);

// File: bench/smem_checker.sv
`timescale 1ns/1ps

module smem_checker
	import smem_pkg::*;
(
	input  logic               clk,
	input  logic               reset_n,
	input  logic [BATCH_W-1:0] batch_size,
	input  read_num_t          curr_read_num_1,
	input  logic               curr_we_1,
	input  entry_t             curr_data_1,
	input  slot_addr_t         curr_addr_1,
	input  entry_t             curr_q_1,
	input  read_num_t          curr_read_num_2,
	input  logic               curr_we_2,
	input  entry_t             curr_data_2,
	input  slot_addr_t         curr_addr_2,
	input  entry_t             curr_q_2,
	input  read_num_t          mem_read_num_1,
	input  logic               mem_we_1,
	input  entry_t             mem_data_1,
	input  slot_addr_t         mem_addr_1,
	input  entry_t             mem_q_1,
	input  read_num_t          mem_read_num_2,
	input  logic               mem_we_2,
	input  entry_t             mem_data_2,
	input  slot_addr_t         mem_addr_2,
	input  entry_t             mem_q_2,
	input  logic               mem_size_valid,
	input  mem_size_t          mem_size,
	input  read_num_t          mem_size_read_num,
	input  logic               ret_valid,
	input  ret_t               ret,
	input  read_num_t          ret_read_num,
	input  logic               output_request,
	input  out_word_t          output_data,
	input  logic               output_valid,
	input  logic               output_finish,
	input  logic               report,
	input  int                 timeout_count,
	input  int                 assert_count,
	output int                 error_count
);

	// queue 0 is curr, queue 1 is mem; full written words, pruned on readback
	entry_t    model [2][SLOT_DEPTH];
	bit        known [2][SLOT_DEPTH];
	// ports 0 and 1 on curr, 2 and 3 on mem
	bit        exp_ok [4];
	entry_t    exp_q [4];
	bit        wr_pend [4];
	int        wr_idx [4];
	entry_t    wr_data [4];
	mem_size_t size_model [NUM_READS];
	ret_t      ret_model [NUM_READS];
	int        strobe_cnt;
	int        rd;
	int        k;
	int        mismatch_count;
	bit        req_d;
	bit        req_exp;
	bit        armed;
	bit        rst_edge;
	bit        fin_seen;
	bit        prev_valid;
	logic      live;

	// ----------------------------------------
	// reference functions
	// ----------------------------------------
	// 33 low bits of x0, x1, x2 and two 7-bit pieces of the info lane
	function automatic entry_t expect_slot(input entry_t e);
		entry_t m;
		int l;
		m = '0;
		for (l = 0; l < 3; l++) begin
			m[l*64 +: 33] = '1;
		end
		m[192 +: 7] = '1;
		m[224 +: 7] = '1;
		return e & m;
	endfunction

	// beat 0 is the header, beat k covers slots 2k-2 and 2k-1
	function automatic out_word_t expect_beat(input int r, input int beat_no);
		out_word_t w;
		int s;
		w = '0;
		if (beat_no == 0) begin
			w[9:0] = 10'(r);
			w[HDR_SIZE_LSB +: MEM_SIZE_W] = size_model[r];
			w[HDR_RET_LSB +: RET_W] = ret_model[r];
		end else begin
			s = 2 * (beat_no - 1);
			w[255:0] = expect_slot(model[1][r*NUM_SLOTS + s]);
			if (s + 1 < size_model[r]) begin
				w[511:256] = expect_slot(model[1][r*NUM_SLOTS + s + 1]);
			end
		end
		return w;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		mismatch_count++;
	endtask

	// reads see the contents from before this edge
	task automatic predict_q(input int p, input logic we, input read_num_t rn,
			input slot_addr_t a, input entry_t d, input logic port_live);
		int qs;
		int idx;
		qs = p / 2;
		idx = {rn, a};
		wr_pend[p] = port_live && we;
		wr_idx[p] = idx;
		wr_data[p] = d;
		exp_ok[p] = port_live && (we || known[qs][idx]);
		exp_q[p] = we ? d : expect_slot(model[qs][idx]);
	endtask

	task automatic check_q(input int p, input entry_t q, input string name);
		if (exp_ok[p] && q !== exp_q[p]) begin
			report_mismatch($sformatf("%s is %h, expected %h", name, q, exp_q[p]));
		end
	endtask

	task automatic check_beat();
		out_word_t exp;
		if (rd >= batch_size) begin
			report_mismatch("output_valid high after the last read");
			return;
		end
		exp = expect_beat(rd, k);
		if (output_data !== exp) begin
			report_mismatch($sformatf("read %0d beat %0d is %h, expected %h",
				rd, k, output_data, exp));
		end
		if (k == 0 && rd != 0 && prev_valid) begin
			report_mismatch($sformatf("no idle cycle before the header of read %0d", rd));
		end
		k++;
		if (k == 1 + (size_model[rd] + 1) / 2) begin
			rd++;
			k = 0;
		end
	endtask

	task automatic restart_model();
		int i;
		for (i = 0; i < NUM_READS; i++) begin
			size_model[i] = '0;
			ret_model[i] = '0;
		end
		strobe_cnt = 0;
		req_d = 1'b0;
		req_exp = 1'b0;
		rd = 0;
		k = 0;
		fin_seen = 1'b0;
		prev_valid = 1'b0;
	endtask

	initial begin
		mismatch_count = 0;
		error_count = 0;
		armed = 1'b0;
	end

	// ----------------------------------------
	// model update at the rising edge
	// ----------------------------------------
	always @(posedge clk) begin
		// the drain owns the mem ports between request and finish
		live = !output_request || output_finish;
		predict_q(0, curr_we_1, curr_read_num_1, curr_addr_1, curr_data_1, 1'b1);
		predict_q(1, curr_we_2, curr_read_num_2, curr_addr_2, curr_data_2, 1'b1);
		predict_q(2, mem_we_1, mem_read_num_1, mem_addr_1, mem_data_1, live);
		predict_q(3, mem_we_2, mem_read_num_2, mem_addr_2, mem_data_2, live);
		for (int p = 0; p < 4; p++) begin
			if (wr_pend[p]) begin
				model[p / 2][wr_idx[p]] = wr_data[p];
				known[p / 2][wr_idx[p]] = 1'b1;
			end
		end
		rst_edge = !reset_n;
		if (!reset_n) begin
			armed = 1'b1;
			restart_model();
		end else begin
			// request follows the last strobe by two edges
			req_exp = req_d;
			if (strobe_cnt == batch_size) begin
				req_d = 1'b1;
			end
			if (mem_size_valid) begin
				strobe_cnt++;
				size_model[mem_size_read_num] = mem_size;
			end
			if (ret_valid) begin
				ret_model[ret_read_num] = ret;
			end
		end
	end

	// ----------------------------------------
	// compare at the falling edge
	// ----------------------------------------
	always @(negedge clk) begin
		if (armed) begin
			check_q(0, curr_q_1, "curr_q_1");
			check_q(1, curr_q_2, "curr_q_2");
			check_q(2, mem_q_1, "mem_q_1");
			check_q(3, mem_q_2, "mem_q_2");
			if (output_request !== req_exp) begin
				report_mismatch($sformatf("output_request is %b, expected %b",
					output_request, req_exp));
			end
			if (rst_edge && (output_valid !== 1'b0 || output_finish !== 1'b0)) begin
				report_mismatch("output_valid or output_finish not low in reset");
			end
			if (output_valid === 1'b1) begin
				check_beat();
			end
			if (output_finish === 1'b1 && !fin_seen) begin
				fin_seen = 1'b1;
				if (rd != batch_size || k != 0) begin
					report_mismatch($sformatf("output_finish high after %0d of %0d reads",
						rd, batch_size));
				end
			end
			prev_valid = (output_valid === 1'b1);
		end
	end

	always @(posedge report) begin
		error_count = mismatch_count + timeout_count + assert_count;
		$display("checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, assert_count);
	end

endmodule

// File: bench/smem_result_buffer_tb.sv
`timescale 1ns/1ps

module smem_result_buffer_tb
	import smem_pkg::*;
();

	logic               clk;
	logic               reset_n;
	logic               stall;
	logic [BATCH_W-1:0] batch_size;
	read_num_t          curr_read_num_1;
	logic               curr_we_1;
	entry_t             curr_data_1;
	slot_addr_t         curr_addr_1;
	entry_t             curr_q_1;
	read_num_t          curr_read_num_2;
	logic               curr_we_2;
	entry_t             curr_data_2;
	slot_addr_t         curr_addr_2;
	entry_t             curr_q_2;
	read_num_t          mem_read_num_1;
	logic               mem_we_1;
	entry_t             mem_data_1;
	slot_addr_t         mem_addr_1;
	entry_t             mem_q_1;
	read_num_t          mem_read_num_2;
	logic               mem_we_2;
	entry_t             mem_data_2;
	slot_addr_t         mem_addr_2;
	entry_t             mem_q_2;
	logic               mem_size_valid;
	mem_size_t          mem_size;
	read_num_t          mem_size_read_num;
	logic               ret_valid;
	ret_t               ret;
	read_num_t          ret_read_num;
	logic               output_request;
	logic               output_permit;
	out_word_t          output_data;
	logic               output_valid;
	logic               output_finish;
	logic               report;
	int                 timeout_count;
	int                 error_count;
	// same return codes for both drains
	ret_t               ret_vals [NUM_READS];

	initial clk = 1'b0;
	always #50 clk = ~clk;

	smem_result_buffer i_smem_result_buffer (.*);

	smem_checker i_checker (
		.assert_count (i_smem_result_buffer.i_asserts.fail_count),
		.*
	);

	function automatic entry_t rand_entry();
		entry_t e;
		int i;
		for (i = 0; i < 8; i++) begin
			e[i*32 +: 32] = $urandom;
		end
		return e;
	endfunction

	// port 1 of both queues on one slot, port 2 on another
	task automatic drive_ports(input logic we, input read_num_t rn_1, input slot_addr_t a_1,
			input read_num_t rn_2, input slot_addr_t a_2);
		curr_we_1 = we;
		curr_read_num_1 = rn_1;
		curr_addr_1 = a_1;
		curr_data_1 = rand_entry();
		curr_we_2 = we;
		curr_read_num_2 = rn_2;
		curr_addr_2 = a_2;
		curr_data_2 = rand_entry();
		mem_we_1 = we;
		mem_read_num_1 = rn_1;
		mem_addr_1 = a_1;
		mem_data_1 = rand_entry();
		mem_we_2 = we;
		mem_read_num_2 = rn_2;
		mem_addr_2 = a_2;
		mem_data_2 = rand_entry();
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic fill_queues();
		int r;
		int s;
		for (r = 0; r < NUM_READS / 2; r++) begin
			for (s = 0; s < NUM_SLOTS; s++) begin
				@(negedge clk);
				// port 2 fills the upper half of the reads in the same cycle
				drive_ports(1'b1, read_num_t'(r), slot_addr_t'(s),
					read_num_t'(r + NUM_READS / 2), slot_addr_t'(s));
			end
		end
	endtask

	task automatic read_back(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			drive_ports(1'b0, read_num_t'($urandom), slot_addr_t'($urandom),
				read_num_t'($urandom), slot_addr_t'($urandom));
		end
	endtask

	// return codes first, then sizes 0 to 8 in reverse read order with gaps
	task automatic load_tables();
		int i;
		for (i = 0; i < NUM_READS; i++) begin
			@(negedge clk);
			ret_valid = 1'b1;
			ret_read_num = read_num_t'(i);
			ret = ret_vals[i];
		end
		@(negedge clk);
		ret_valid = 1'b0;
		for (i = 0; i < NUM_READS; i++) begin
			mem_size_valid = 1'b1;
			mem_size_read_num = read_num_t'(NUM_READS - 1 - i);
			mem_size = mem_size_t'((NUM_READS - 1 - i) % (NUM_SLOTS + 1));
			@(negedge clk);
			mem_size_valid = 1'b0;
			repeat ($urandom_range(0, 2)) @(negedge clk);
		end
	endtask

	task automatic wait_request(input int limit);
		int n;
		n = 0;
		while (output_request !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (output_request !== 1'b1) begin
			$display("timeout: output_request still low after %0d cycles", limit);
			timeout_count++;
		end
	endtask

	task automatic wait_finish(input int limit, input bit rand_stall);
		int n;
		n = 0;
		while (output_finish !== 1'b1 && n < limit) begin
			@(negedge clk);
			stall = rand_stall && ($urandom_range(0, 3) == 0);
			n++;
		end
		stall = 1'b0;
		if (output_finish !== 1'b1) begin
			$display("timeout: output_finish still low after %0d cycles", limit);
			timeout_count++;
		end
	endtask

	initial begin
		int i;
		void'($urandom(32'hbfb5ea4c));
		reset_n = 1'b0;
		stall = 1'b0;
		batch_size = BATCH_W'(NUM_READS);
		output_permit = 1'b0;
		mem_size_valid = 1'b0;
		mem_size = '0;
		mem_size_read_num = '0;
		ret_valid = 1'b0;
		ret = '0;
		ret_read_num = '0;
		report = 1'b0;
		timeout_count = 0;
		drive_ports(1'b0, '0, '0, '0, '0);
		for (i = 0; i < NUM_READS; i++) begin
			ret_vals[i] = $urandom;
		end
		apply_reset();

		// ----------------------------------------
		// queue write-through and readback
		// ----------------------------------------
		fill_queues();
		read_back(64);

		// ----------------------------------------
		// drain with early permit, no stall
		// ----------------------------------------
		output_permit = 1'b1;
		load_tables();
		wait_request(50);
		wait_finish(500, 1'b0);

		// ----------------------------------------
		// drain with late permit and random stall
		// ----------------------------------------
		output_permit = 1'b0;
		apply_reset();
		load_tables();
		wait_request(50);
		repeat ($urandom_range(4, 12)) @(negedge clk);
		output_permit = 1'b1;
		wait_finish(1000, 1'b1);

		repeat (2) @(negedge clk);
		report = 1'b1;
		#1;
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
verilog/smem_pkg.sv
verilog/slot_queue_ram.sv
verilog/read_table.sv
verilog/beat_formatter.sv
verilog/smem_output_ctrl.sv
verilog/smem_result_buffer.sv
bench/smem_result_buffer_asserts.sv
bench/smem_checker.sv
bench/smem_result_buffer_tb.sv

// File: Bender.yml
package:
  name: smem_result_buffer

sources:
  - verilog/smem_pkg.sv
  - verilog/slot_queue_ram.sv
  - verilog/read_table.sv
  - verilog/beat_formatter.sv
  - verilog/smem_output_ctrl.sv
  - verilog/smem_result_buffer.sv
  - target: test
    files:
      - bench/smem_result_buffer_asserts.sv
      - bench/smem_checker.sv
      - bench/smem_result_buffer_tb.sv
